// File: common/eu_pkg.sv
`default_nettype none

package eu_pkg;

  // cluster sizes
  localparam int NB_CORES       = 4;
  localparam int NB_SW_EVT      = 8;
  localparam int NB_BARR        = 2;
  localparam int NB_EXT_EVT     = 2;
  localparam int SOC_FIFO_DEPTH = 4;
  localparam int EVNT_WIDTH     = 8;

  // event word and event index widths
  localparam int EVT_WORD_W = 32;
  localparam int EVT_ID_W   = 5;

  // config index addresses either a core or a barrier, NB_CORES is the larger range
  localparam int CFG_IDX_W = $clog2(NB_CORES);

  // soc fifo pointer and fill counter widths
  localparam int SOC_FIFO_PTR_W = $clog2(SOC_FIFO_DEPTH);
  localparam int SOC_FIFO_CNT_W = $clog2(SOC_FIFO_DEPTH + 1);

  // config select values
  localparam logic CFG_SEL_MASK = 1'b0;
  localparam logic CFG_SEL_BARR = 1'b1;

  // bit positions in the event word
  localparam int SW_EVT_LSB     = 0;
  localparam int BARR_EVT_LSB   = 8;
  localparam int PERIPH_EVT_BIT = 10;
  localparam int EXT_EVT_LSB    = 11;
  localparam int EVT_RSVD_LSB   = EXT_EVT_LSB + NB_EXT_EVT;

  // one bit per core
  typedef logic [NB_CORES-1:0] core_mask_t;

  // field layout, msb first
  typedef struct packed {
    logic [EVT_WORD_W-EVT_RSVD_LSB-1:0]     reserved;
    logic [EVT_RSVD_LSB-EXT_EVT_LSB-1:0]    ext;
    logic [EXT_EVT_LSB-PERIPH_EVT_BIT-1:0]  periph;
    logic [PERIPH_EVT_BIT-BARR_EVT_LSB-1:0] barr;
    logic [BARR_EVT_LSB-SW_EVT_LSB-1:0]     sw;
  } eu_evt_fields_t;

  // same word seen flat (buffer, mask, config data) or by source field
  typedef union packed {
    logic [EVT_WORD_W-1:0] flat;
    eu_evt_fields_t        fields;
  } eu_evt_word_u;

endpackage

`default_nettype wire

// File: rtl/soc_evt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module soc_evt_fifo (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          valid_i,
  input  logic [eu_pkg::EVNT_WIDTH-1:0] data_i,
  output logic                          ready_o,
  input  logic                          pop_i,
  output logic [eu_pkg::EVNT_WIDTH-1:0] data_o,
  output logic                          not_empty_o
);

  logic [eu_pkg::EVNT_WIDTH-1:0]     mem_q [eu_pkg::SOC_FIFO_DEPTH];
  logic [eu_pkg::SOC_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [eu_pkg::SOC_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [eu_pkg::SOC_FIFO_CNT_W-1:0] count_q;
  logic                              push;
  logic                              pop;

  assign ready_o     = int'(count_q) != eu_pkg::SOC_FIFO_DEPTH;
  assign not_empty_o = count_q != '0;

  // pop on an empty fifo has no effect
  assign push = valid_i & ready_o;
  assign pop  = pop_i & not_empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == eu_pkg::SOC_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == eu_pkg::SOC_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the fill level
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/sw_evt_router.sv
`timescale 1ns/1ps
`default_nettype none

module sw_evt_router (
  // trigger vector and target mask, indexed by source core
  input  logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_SW_EVT-1:0] trig_i,
  input  eu_pkg::core_mask_t [eu_pkg::NB_CORES-1:0]          target_i,
  // event lines, indexed by destination core
  output logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_SW_EVT-1:0] sw_lines_o
);

  // per event: which sources fire it, per destination: which sources target it
  logic [eu_pkg::NB_SW_EVT-1:0][eu_pkg::NB_CORES-1:0] trig_t;
  logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_CORES-1:0]  target_t;

  always_comb begin
    for (int src = 0; src < eu_pkg::NB_CORES; src++) begin
      for (int e = 0; e < eu_pkg::NB_SW_EVT; e++) begin
        trig_t[e][src] = trig_i[src][e];
      end
      for (int dst = 0; dst < eu_pkg::NB_CORES; dst++) begin
        target_t[dst][src] = target_i[src][dst];
      end
    end
  end

  // event e reaches core dst if any source fires e with dst in its target mask
  always_comb begin
    for (int dst = 0; dst < eu_pkg::NB_CORES; dst++) begin
      for (int e = 0; e < eu_pkg::NB_SW_EVT; e++) begin
        sw_lines_o[dst][e] = |(trig_t[e] & target_t[dst]);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/hw_barrier_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hw_barrier_unit #(
  parameter int BARR_ID = 0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cfg_we_i,
  input  logic                          cfg_sel_i,
  input  logic [eu_pkg::CFG_IDX_W-1:0]  cfg_idx_i,
  input  logic [eu_pkg::EVT_WORD_W-1:0] cfg_wdata_i,
  input  eu_pkg::core_mask_t            arrive_i,
  output eu_pkg::core_mask_t            part_o,
  output logic                          evt_o
);

  eu_pkg::core_mask_t part_q;
  eu_pkg::core_mask_t status_q;
  eu_pkg::core_mask_t status_next;
  logic               part_we;
  logic               complete;
  logic               evt_q;

  assign part_we = cfg_we_i && (cfg_sel_i == eu_pkg::CFG_SEL_BARR) &&
                   (int'(cfg_idx_i) == BARR_ID);

  // arrivals from cores outside the participant mask are dropped
  assign status_next = (status_q | arrive_i) & part_q;

  // an empty participant mask never completes
  assign complete = (part_q != '0) && (status_next == part_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      part_q   <= '0;
      status_q <= '0;
      evt_q    <= 1'b0;
    end else begin
      evt_q <= complete;
      if (part_we) begin
        // new participant set, restart the barrier
        part_q   <= cfg_wdata_i[eu_pkg::NB_CORES-1:0];
        status_q <= '0;
      end else if (complete) begin
        status_q <= '0;
      end else begin
        status_q <= status_next;
      end
    end
  end

  assign part_o = part_q;
  assign evt_o  = evt_q;

endmodule

`default_nettype wire

// File: eu_core/eu_core.sv
`timescale 1ns/1ps
`default_nettype none

module eu_core #(
  parameter int CORE_ID = 0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // configuration strobe, shared by all cores
  input  logic                                 cfg_we_i,
  input  logic                                 cfg_sel_i,
  input  logic [eu_pkg::CFG_IDX_W-1:0]         cfg_idx_i,
  input  logic [eu_pkg::EVT_WORD_W-1:0]        cfg_wdata_i,

  // event sources
  input  logic [eu_pkg::NB_SW_EVT-1:0]         sw_lines_i,
  input  logic [eu_pkg::NB_BARR-1:0]           barr_evt_i,
  input  eu_pkg::core_mask_t [eu_pkg::NB_BARR-1:0] barr_part_i,
  input  logic                                 periph_evt_i,
  input  logic [eu_pkg::NB_EXT_EVT-1:0]        ext_evt_i,

  // core side
  input  logic                                 wait_i,
  input  logic                                 clr_i,
  output logic                                 clk_en_o,
  output logic                                 evt_valid_o,
  output logic [eu_pkg::EVT_ID_W-1:0]          evt_id_o
);

  eu_pkg::eu_evt_word_u          evt_in;
  eu_pkg::eu_evt_word_u          evt_buf_q;
  eu_pkg::eu_evt_word_u          evt_mask_q;
  logic [eu_pkg::EVT_WORD_W-1:0] evt_masked;
  logic [eu_pkg::EVT_WORD_W-1:0] clr_word;
  logic [eu_pkg::NB_BARR-1:0]    barr_mine;
  logic                          mask_we;

  // a barrier event counts only for its participants
  always_comb begin
    for (int b = 0; b < eu_pkg::NB_BARR; b++) begin
      barr_mine[b] = barr_evt_i[b] & barr_part_i[b][CORE_ID];
    end
  end

  // assemble this cycle's events by source
  always_comb begin
    evt_in               = '0;
    evt_in.fields.sw     = sw_lines_i;
    evt_in.fields.barr   = barr_mine;
    evt_in.fields.periph = periph_evt_i;
    evt_in.fields.ext    = ext_evt_i;
  end

  assign mask_we = cfg_we_i && (cfg_sel_i == eu_pkg::CFG_SEL_MASK) &&
                   (int'(cfg_idx_i) == CORE_ID);

  assign evt_masked  = evt_buf_q.flat & evt_mask_q.flat;
  assign evt_valid_o = evt_masked != '0;

  // lowest set index wins, scan downwards so the last hit is the lowest
  always_comb begin
    evt_id_o = '0;
    for (int k = eu_pkg::EVT_WORD_W - 1; k >= 0; k--) begin
      if (evt_masked[k]) begin
        evt_id_o = k[eu_pkg::EVT_ID_W-1:0];
      end
    end
  end

  // clear hits only the bit currently reported
  always_comb begin
    clr_word = '0;
    if (clr_i && evt_valid_o) begin
      clr_word[evt_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      evt_buf_q  <= '0;
      evt_mask_q <= '0;
    end else begin
      // new event is ORed in after the clear, so it survives a same-edge clear
      evt_buf_q.flat <= (evt_buf_q.flat & ~clr_word) | evt_in.flat;
      if (mask_we) begin
        evt_mask_q.flat <= cfg_wdata_i;
      end
    end
  end

  // clock stays gated only while waiting with nothing pending
  assign clk_en_o = ~(wait_i & ~evt_valid_o);

endmodule

`default_nettype wire

// File: rtl/event_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module event_unit_top (
  input  logic                                                clk_i,
  input  logic                                                rst_i,

  // software events, one trigger vector and one target mask per core
  input  logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_SW_EVT-1:0]  sw_trig_i,
  input  eu_pkg::core_mask_t [eu_pkg::NB_CORES-1:0]           sw_target_i,

  // barrier arrivals, one core mask per barrier
  input  eu_pkg::core_mask_t [eu_pkg::NB_BARR-1:0]            barr_arrive_i,

  input  logic [eu_pkg::NB_EXT_EVT-1:0]                       ext_evt_i,

  // soc peripheral event fifo
  input  logic                                                soc_evt_valid_i,
  input  logic [eu_pkg::EVNT_WIDTH-1:0]                       soc_evt_data_i,
  output logic                                                soc_evt_ready_o,
  input  logic                                                soc_evt_pop_i,
  output logic [eu_pkg::EVNT_WIDTH-1:0]                       soc_evt_data_o,

  // configuration strobe
  input  logic                                                cfg_we_i,
  input  logic                                                cfg_sel_i,
  input  logic [eu_pkg::CFG_IDX_W-1:0]                        cfg_idx_i,
  input  logic [eu_pkg::EVT_WORD_W-1:0]                       cfg_wdata_i,

  // per core
  input  logic [eu_pkg::NB_CORES-1:0]                         wait_i,
  input  logic [eu_pkg::NB_CORES-1:0]                         clr_i,
  output logic [eu_pkg::NB_CORES-1:0]                         core_clk_en_o,
  output logic [eu_pkg::NB_CORES-1:0]                         core_evt_valid_o,
  output logic [eu_pkg::NB_CORES-1:0][eu_pkg::EVT_ID_W-1:0]   core_evt_id_o
);

  logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_SW_EVT-1:0] sw_lines;
  logic [eu_pkg::NB_BARR-1:0]                         barr_evt;
  eu_pkg::core_mask_t [eu_pkg::NB_BARR-1:0]           barr_part;
  logic                                               periph_evt;

  soc_evt_fifo soc_evt_fifo_i (
    .clk_i       ( clk_i           ),
    .rst_i       ( rst_i           ),
    .valid_i     ( soc_evt_valid_i ),
    .data_i      ( soc_evt_data_i  ),
    .ready_o     ( soc_evt_ready_o ),
    .pop_i       ( soc_evt_pop_i   ),
    .data_o      ( soc_evt_data_o  ),
    .not_empty_o ( periph_evt      )
  );

  sw_evt_router sw_evt_router_i (
    .trig_i     ( sw_trig_i   ),
    .target_i   ( sw_target_i ),
    .sw_lines_o ( sw_lines    )
  );

  for (genvar b = 0; b < eu_pkg::NB_BARR; b++) begin : gen_barr
    hw_barrier_unit #(
      .BARR_ID ( b )
    ) hw_barrier_unit_i (
      .clk_i       ( clk_i            ),
      .rst_i       ( rst_i            ),
      .cfg_we_i    ( cfg_we_i         ),
      .cfg_sel_i   ( cfg_sel_i        ),
      .cfg_idx_i   ( cfg_idx_i        ),
      .cfg_wdata_i ( cfg_wdata_i      ),
      .arrive_i    ( barr_arrive_i[b] ),
      .part_o      ( barr_part[b]     ),
      .evt_o       ( barr_evt[b]      )
    );
  end

  for (genvar c = 0; c < eu_pkg::NB_CORES; c++) begin : gen_core
    eu_core #(
      .CORE_ID ( c )
    ) eu_core_i (
      .clk_i        ( clk_i               ),
      .rst_i        ( rst_i               ),
      .cfg_we_i     ( cfg_we_i            ),
      .cfg_sel_i    ( cfg_sel_i           ),
      .cfg_idx_i    ( cfg_idx_i           ),
      .cfg_wdata_i  ( cfg_wdata_i         ),
      .sw_lines_i   ( sw_lines[c]         ),
      .barr_evt_i   ( barr_evt            ),
      .barr_part_i  ( barr_part           ),
      .periph_evt_i ( periph_evt          ),
      .ext_evt_i    ( ext_evt_i           ),
      .wait_i       ( wait_i[c]           ),
      .clr_i        ( clr_i[c]            ),
      .clk_en_o     ( core_clk_en_o[c]    ),
      .evt_valid_o  ( core_evt_valid_o[c] ),
      .evt_id_o     ( core_evt_id_o[c]    )
    );
  end

endmodule

`default_nettype wire

// File: sim/tb_event_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_event_unit;

  localparam int RST_CYCLES = 10;
  localparam int WAIT_LIMIT = 100;

  logic                                               clk;
  logic                                               rst;
  logic [eu_pkg::NB_CORES-1:0][eu_pkg::NB_SW_EVT-1:0] sw_trig;
  eu_pkg::core_mask_t [eu_pkg::NB_CORES-1:0]          sw_target;
  eu_pkg::core_mask_t [eu_pkg::NB_BARR-1:0]           barr_arrive;
  logic [eu_pkg::NB_EXT_EVT-1:0]                      ext_evt;
  logic                                               soc_evt_valid;
  logic [eu_pkg::EVNT_WIDTH-1:0]                      soc_evt_wdata;
  logic                                               soc_evt_ready;
  logic                                               soc_evt_pop;
  logic [eu_pkg::EVNT_WIDTH-1:0]                      soc_evt_rdata;
  logic                                               cfg_we;
  logic                                               cfg_sel;
  logic [eu_pkg::CFG_IDX_W-1:0]                       cfg_idx;
  logic [eu_pkg::EVT_WORD_W-1:0]                      cfg_wdata;
  logic [eu_pkg::NB_CORES-1:0]                        wait_lvl;
  logic [eu_pkg::NB_CORES-1:0]                        clr;
  logic [eu_pkg::NB_CORES-1:0]                        core_clk_en;
  logic [eu_pkg::NB_CORES-1:0]                        core_evt_valid;
  logic [eu_pkg::NB_CORES-1:0][eu_pkg::EVT_ID_W-1:0]  core_evt_id;

  event_unit_top dut_i (
    .clk_i            ( clk            ),
    .rst_i            ( rst            ),
    .sw_trig_i        ( sw_trig        ),
    .sw_target_i      ( sw_target      ),
    .barr_arrive_i    ( barr_arrive    ),
    .ext_evt_i        ( ext_evt        ),
    .soc_evt_valid_i  ( soc_evt_valid  ),
    .soc_evt_data_i   ( soc_evt_wdata  ),
    .soc_evt_ready_o  ( soc_evt_ready  ),
    .soc_evt_pop_i    ( soc_evt_pop    ),
    .soc_evt_data_o   ( soc_evt_rdata  ),
    .cfg_we_i         ( cfg_we         ),
    .cfg_sel_i        ( cfg_sel        ),
    .cfg_idx_i        ( cfg_idx        ),
    .cfg_wdata_i      ( cfg_wdata      ),
    .wait_i           ( wait_lvl       ),
    .clr_i            ( clr            ),
    .core_clk_en_o    ( core_clk_en    ),
    .core_evt_valid_o ( core_evt_valid ),
    .core_evt_id_o    ( core_evt_id    )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("FAILED %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  // source holds valid and data until the fifo has room
  task automatic push_event(input logic [eu_pkg::EVNT_WIDTH-1:0] data);
    int cycles;
    cycles = 0;
    while (!soc_evt_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run("timeout while waiting for the SoC FIFO to accept a push");
      end
    end
    soc_evt_valid = 1'b1;
    soc_evt_wdata = data;
    @(negedge clk);
    soc_evt_valid = 1'b0;
  endtask

  task automatic drive_command(input string cmd, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] c);
    case (cmd)
      "cfg": begin
        cfg_we    = 1'b1;
        cfg_sel   = a[0];
        cfg_idx   = b[eu_pkg::CFG_IDX_W-1:0];
        cfg_wdata = c;
      end
      "trig": begin
        sw_trig[a[1:0]]   = b[eu_pkg::NB_SW_EVT-1:0];
        sw_target[a[1:0]] = c[eu_pkg::NB_CORES-1:0];
      end
      "arrive": barr_arrive[a[0]] = b[eu_pkg::NB_CORES-1:0];
      "ext":    ext_evt = a[eu_pkg::NB_EXT_EVT-1:0];
      "pop":    soc_evt_pop = 1'b1;
      "clr":    clr = a[eu_pkg::NB_CORES-1:0];
      "wait":   wait_lvl = a[eu_pkg::NB_CORES-1:0];
      "push":   push_event(a[eu_pkg::EVNT_WIDTH-1:0]);
      "idle":   repeat (a) @(negedge clk);
      "reset":  apply_reset();
      default:  stop_run({"unknown command in the stimulus file: ", cmd});
    endcase
    // pulses last one clock, wait stays as a level
    @(negedge clk);
    cfg_we      = 1'b0;
    sw_trig     = '0;
    sw_target   = '0;
    barr_arrive = '0;
    ext_evt     = '0;
    soc_evt_pop = 1'b0;
    clr         = '0;
  endtask

  task automatic run_command(input string name, input string cmd, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] c);
    case (cmd)
      "valid": compare(name, b, core_evt_valid);
      "clken": compare(name, b, core_clk_en);
      "ready": compare(name, b, soc_evt_ready);
      "data":  compare(name, b, soc_evt_rdata);
      "id":    compare(name, b, core_evt_id[a[1:0]]);
      default: begin
        drive_command(cmd, a, b, c);
        // random idle gap between commands
        repeat ($urandom_range(3, 1)) @(negedge clk);
      end
    endcase
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    string       cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;

    rst           = 1'b1;
    sw_trig       = '0;
    sw_target     = '0;
    barr_arrive   = '0;
    ext_evt       = '0;
    soc_evt_valid = 1'b0;
    soc_evt_wdata = '0;
    soc_evt_pop   = 1'b0;
    cfg_we        = 1'b0;
    cfg_sel       = 1'b0;
    cfg_idx       = '0;
    cfg_wdata     = '0;
    wait_lvl      = '0;
    clr           = '0;
    void'($urandom(32'h8b7c9ab4));

    fd = $fopen("sim/eu_stim.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the stimulus file sim/eu_stim.txt");
    end
    apply_reset();

    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip comment and blank lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h", name, cmd, a, b, c);
        if (n != 5) begin
          stop_run({"malformed line in the stimulus file: ", line});
        end
        run_command(name, cmd, a, b, c);
      end
    end
    $fclose(fd);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/eu_stim.txt
# columns: test command a b c, operands in hex, unused operands are 0
# cfg sel idx data, trig src evts targets, arrive barr cores, checks compare core a with b
reset   valid  0 0 0
reset   clken  0 f 0
reset   ready  0 1 0
sw_evt  cfg    0 0 500
sw_evt  cfg    0 1 24
sw_evt  cfg    0 2 1100
sw_evt  cfg    0 3 1
sw_evt  trig   0 24 a
sw_evt  valid  0 2 0
sw_evt  id     1 2 0
sw_evt  clr    2 0 0
sw_evt  id     1 5 0
sw_evt  clr    2 0 0
sw_evt  valid  0 0 0
barrier cfg    1 0 5
barrier arrive 0 3 0
barrier idle   2 0 0
barrier valid  0 0 0
barrier arrive 0 4 0
barrier idle   2 0 0
barrier valid  0 5 0
barrier id     0 8 0
barrier id     2 8 0
barrier clr    5 0 0
barrier valid  0 0 0
barrier arrive 0 5 0
barrier idle   2 0 0
barrier valid  0 5 0
barrier clr    5 0 0
fifo    push   3 0 0
fifo    push   5 0 0
fifo    push   7 0 0
fifo    push   9 0 0
fifo    ready  0 0 0
fifo    valid  0 1 0
fifo    id     0 a 0
fifo    data   0 3 0
fifo    pop    0 0 0
fifo    data   0 5 0
fifo    pop    0 0 0
fifo    data   0 7 0
fifo    pop    0 0 0
fifo    data   0 9 0
fifo    pop    0 0 0
fifo    ready  0 1 0
fifo    valid  0 1 0
fifo    clr    1 0 0
fifo    valid  0 0 0
gating  wait   f 0 0
gating  clken  0 0 0
gating  ext    1 0 0
gating  clken  0 0 0
gating  ext    2 0 0
gating  clken  0 4 0
gating  id     2 c 0
midrst  wait   0 0 0
midrst  reset  0 0 0
midrst  valid  0 0 0
midrst  clken  0 f 0
midrst  ready  0 1 0
midrst  trig   0 24 2
midrst  valid  0 0 0

// File: flist.f
common/eu_pkg.sv
rtl/soc_evt_fifo.sv
rtl/sw_evt_router.sv
rtl/hw_barrier_unit.sv
eu_core/eu_core.sv
rtl/event_unit_top.sv
sim/tb_event_unit.sv
